// File: Bender.yml
package:
  name: cdp_rdma_ig

sources:
  - logic/cdp_rdma_cfg_pkg.sv
  - logic/cdp_rdma_req_pkg.sv
  - logic/cdp_rdma_ig_ctrl.sv
  - logic/cdp_rdma_cube_walk.sv
  - logic/cdp_rdma_addr_gen.sv
  - logic/cdp_rdma_stall_perf.sv
  - logic/cdp_rdma_ig.sv
  - target: simulation
    files:
      - tb/cdp_rdma_ig_tb.sv

// File: all.f
logic/cdp_rdma_cfg_pkg.sv
logic/cdp_rdma_req_pkg.sv
logic/cdp_rdma_ig_ctrl.sv
logic/cdp_rdma_cube_walk.sv
logic/cdp_rdma_addr_gen.sv
logic/cdp_rdma_stall_perf.sv
logic/cdp_rdma_ig.sv
tb/cdp_rdma_ig_tb.sv

// File: logic/cdp_rdma_addr_gen.sv
/*
 * pooling read DMA ingress address generator
 * line base, group base and request address registers,
 * request size from the width remainder
 */
`timescale 1ns/1ps

module cdp_rdma_addr_gen (
  input  logic                                  nvdla_core_clk,
  input  logic                                  nvdla_core_rstn,
  input  cdp_rdma_cfg_pkg::cdp_rdma_cfg_t       cfg,
  input  logic                                  op_load,
  input  logic                                  cmd_accept,
  input  cdp_rdma_req_pkg::walk_pos_t           pos,
  output logic [cdp_rdma_cfg_pkg::addr_w_c-1:0] req_addr,
  output cdp_rdma_req_pkg::req_size_t           req_size
);

  import cdp_rdma_cfg_pkg::*;

  localparam int pad_w = addr_w_c - 4 - atom_shift_c;

  logic [addr_w_c-1:0] line_base;
  logic [addr_w_c-1:0] grp_base;
  logic [addr_w_c-1:0] surf_ext;
  logic [addr_w_c-1:0] line_ext;
  logic [addr_w_c-1:0] grp_step;
  logic [addr_w_c-1:0] next_line;
  logic [addr_w_c-1:0] next_grp;
  logic [3:0]          req_atoms;

  // ==============================
  // request size
  // ==============================
  // full group except at the end of the line
  assign req_size = pos.last_w ? cfg.width[2:0] : 3'(w_group_c - 1);
  // one extra bit so a full group of 8 fits
  assign req_atoms = {1'b0, req_size} + 4'd1;

  // ==============================
  // next addresses
  // ==============================
  assign surf_ext = {{(addr_w_c-stride_w_c){1'b0}}, cfg.surf_stride};
  assign line_ext = {{(addr_w_c-stride_w_c){1'b0}}, cfg.line_stride};
  // atoms of this group in bytes
  assign grp_step = {{pad_w{1'b0}}, req_atoms, {atom_shift_c{1'b0}}};

  assign next_line = line_base + line_ext;
  assign next_grp  = grp_base + grp_step;

  // ==============================
  // address registers
  // ==============================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      line_base <= '0;
      grp_base  <= '0;
      req_addr  <= '0;
    end else if (op_load) begin
      line_base <= cfg.base_addr;
      grp_base  <= cfg.base_addr;
      req_addr  <= cfg.base_addr;
    end else if (cmd_accept) begin
      if (!pos.last_c) begin
        // next channel group, same width group
        req_addr <= req_addr + surf_ext;
      end else if (!pos.last_w) begin
        // back to first channel group of the next width group
        grp_base <= next_grp;
        req_addr <= next_grp;
      end else begin
        // start of the next line
        line_base <= next_line;
        grp_base  <= next_line;
        req_addr  <= next_line;
      end
    end
  end

endmodule

// File: logic/cdp_rdma_cfg_pkg.sv
/*
 * pooling read DMA ingress, layer configuration
 * atomic constants, geometry widths and the per-layer
 * register view seen by the cube walk and the address generator
 */
package cdp_rdma_cfg_pkg;

  // ==============================
  // atomic constants
  // ==============================
  // one atom is one 32 byte memory word
  localparam int atom_bytes_c = 32;
  localparam int atom_shift_c = $clog2(atom_bytes_c);
  // atoms fetched per width group
  localparam int w_group_c = 8;

  // ==============================
  // widths
  // ==============================
  localparam int dim_w_c = 13;
  localparam int addr_w_c = 64;
  localparam int stride_w_c = 32;
  localparam int perf_w_c = 32;

  // cube dimension, stored minus one
  typedef logic [dim_w_c-1:0] dim_t;

  // ==============================
  // layer configuration
  // ==============================
  typedef struct packed {
    // channels minus one, in bytes
    dim_t channel;
    // lines minus one
    dim_t height;
    // atoms per line minus one
    dim_t width;
    logic [addr_w_c-1:0] base_addr;
    // byte distance between lines
    logic [stride_w_c-1:0] line_stride;
    // byte distance between channel groups
    logic [stride_w_c-1:0] surf_stride;
    // stall counting enable
    logic dma_en;
  } cdp_rdma_cfg_t;

endpackage

// File: logic/cdp_rdma_cube_walk.sv
/*
 * pooling read DMA ingress cube walk
 * channel group, width group and line counters,
 * order is channel groups inside width groups inside lines
 */
`timescale 1ns/1ps

module cdp_rdma_cube_walk (
  input  logic                            nvdla_core_clk,
  input  logic                            nvdla_core_rstn,
  input  cdp_rdma_cfg_pkg::cdp_rdma_cfg_t cfg,
  input  logic                            cmd_accept,
  output cdp_rdma_req_pkg::walk_pos_t     pos
);

  import cdp_rdma_cfg_pkg::*;

  // channel group count bits
  localparam int cg_w = dim_w_c - atom_shift_c;
  localparam int wg_shift = $clog2(w_group_c);
  // width group count bits
  localparam int wg_w = dim_w_c + 1 - wg_shift;

  logic [cg_w-1:0]    c_cnt;
  logic [wg_w-1:0]    w_cnt;
  dim_t               h_cnt;
  logic [dim_w_c:0]   width_use;
  logic [wg_w-1:0]    w_groups;
  logic               is_last_c;
  logic               is_last_w;
  logic               is_last_h;
  logic               slice_end;
  logic               cube_end;

  // ==============================
  // width groups per line
  // ==============================
  assign width_use = {1'b0, cfg.width} + 1'b1;
  // round up, partial last group counts as one
  assign w_groups = width_use[dim_w_c:wg_shift] + wg_w'(|width_use[wg_shift-1:0]);

  // ==============================
  // position flags
  // ==============================
  // channel field holds bytes, upper bits give groups minus one
  assign is_last_c = (c_cnt == cfg.channel[dim_w_c-1:atom_shift_c]);
  assign is_last_w = (w_cnt == w_groups - 1'b1);
  assign is_last_h = (h_cnt == cfg.height);
  assign slice_end = is_last_c & is_last_w;
  assign cube_end  = slice_end & is_last_h;

  assign pos = '{last_w: is_last_w, last_c: is_last_c, last_h: is_last_h};

  // ==============================
  // counters
  // ==============================
  // all three end at zero, ready for the next layer
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      c_cnt <= '0;
      w_cnt <= '0;
      h_cnt <= '0;
    end else if (cmd_accept) begin
      // innermost, channel groups
      if (is_last_c) begin
        c_cnt <= '0;
      end else begin
        c_cnt <= c_cnt + 1'b1;
      end
      // width group steps after its last channel group
      if (slice_end) begin
        w_cnt <= '0;
      end else if (is_last_c) begin
        w_cnt <= w_cnt + 1'b1;
      end
      // next line after a full slice
      if (cube_end) begin
        h_cnt <= '0;
      end else if (slice_end) begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

endmodule

// File: logic/cdp_rdma_ig.sv
/*
 * pooling read DMA ingress stage
 * walks the input cube per layer, issues one read request and
 * one context entry per step, reports stall cycles per layer
 */
`timescale 1ns/1ps

module cdp_rdma_ig (
  input  logic                                  nvdla_core_clk,
  input  logic                                  nvdla_core_rstn,
  input  logic                                  op_en,
  input  cdp_rdma_cfg_pkg::cdp_rdma_cfg_t       cfg,
  input  logic                                  eg2ig_done,
  // read request to memory
  output logic                                  dma_req_valid,
  input  logic                                  dma_req_ready,
  output cdp_rdma_req_pkg::dma_rd_req_t         dma_req_pd,
  // context queue to egress
  output logic                                  cq_valid,
  input  logic                                  cq_ready,
  output cdp_rdma_req_pkg::cq_entry_t           cq_pd,
  output logic [cdp_rdma_cfg_pkg::perf_w_c-1:0] perf_stall_d0,
  output logic [cdp_rdma_cfg_pkg::perf_w_c-1:0] perf_stall_d1
);

  import cdp_rdma_cfg_pkg::*;
  import cdp_rdma_req_pkg::*;

  logic                op_load;
  logic                cmd_accept;
  logic                layer_done;
  walk_pos_t           pos;
  logic [addr_w_c-1:0] req_addr;
  req_size_t           req_size;

  // ==============================
  // control and walk
  // ==============================
  cdp_rdma_ig_ctrl u_ctrl (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_en           (op_en),
    .eg2ig_done      (eg2ig_done),
    .pos             (pos),
    .dma_req_ready   (dma_req_ready),
    .cq_ready        (cq_ready),
    .dma_req_valid   (dma_req_valid),
    .cq_valid        (cq_valid),
    .op_load         (op_load),
    .cmd_accept      (cmd_accept),
    .layer_done      (layer_done)
  );

  cdp_rdma_cube_walk u_cube_walk (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg             (cfg),
    .cmd_accept      (cmd_accept),
    .pos             (pos)
  );

  cdp_rdma_addr_gen u_addr_gen (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg             (cfg),
    .op_load         (op_load),
    .cmd_accept      (cmd_accept),
    .pos             (pos),
    .req_addr        (req_addr),
    .req_size        (req_size)
  );

  // stall counting and perf registers
  cdp_rdma_stall_perf u_stall_perf (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .dma_en          (cfg.dma_en),
    .dma_req_valid   (dma_req_valid),
    .dma_req_ready   (dma_req_ready),
    .layer_done      (layer_done),
    .perf_stall_d0   (perf_stall_d0),
    .perf_stall_d1   (perf_stall_d1)
  );

  // ==============================
  // payloads
  // ==============================
  // both come from registers, steady until accepted
  assign dma_req_pd = '{size: req_size, addr: req_addr};
  assign cq_pd = '{last_c: pos.last_c, last_h: pos.last_h, last_w: pos.last_w,
                   size: req_size};

endmodule

// File: logic/cdp_rdma_ig_ctrl.sv
/*
 * pooling read DMA ingress control
 * layer start and stop, hold until egress is done,
 * joint valid and accept for the DMA and context queue ports
 */
`timescale 1ns/1ps

module cdp_rdma_ig_ctrl (
  input  logic                       nvdla_core_clk,
  input  logic                       nvdla_core_rstn,
  input  logic                       op_en,
  input  logic                       eg2ig_done,
  input  cdp_rdma_req_pkg::walk_pos_t pos,
  input  logic                       dma_req_ready,
  input  logic                       cq_ready,
  output logic                       dma_req_valid,
  output logic                       cq_valid,
  output logic                       op_load,
  output logic                       cmd_accept,
  output logic                       layer_done
);

  logic active;
  logic hold;

  // ==============================
  // layer state
  // ==============================
  // load only when idle and egress has drained the last layer
  assign op_load = op_en & ~active & ~hold;
  // final step of the cube taken
  assign layer_done = cmd_accept & pos.last_w & pos.last_c & pos.last_h;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      active <= 1'b0;
    end else if (layer_done) begin
      active <= 1'b0;
    end else if (op_load) begin
      active <= 1'b1;
    end
  end

  // bubble after the layer, released by egress
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      hold <= 1'b0;
    end else if (layer_done) begin
      hold <= 1'b1;
    end else if (eg2ig_done) begin
      hold <= 1'b0;
    end
  end

  // ==============================
  // joint handshake
  // ==============================
  // each side is only offered when the other can take it,
  // so both ports accept on the same cycle
  assign dma_req_valid = active & cq_ready;
  assign cq_valid      = active & dma_req_ready;
  assign cmd_accept    = active & dma_req_ready & cq_ready;

endmodule

// File: logic/cdp_rdma_req_pkg.sv
/*
 * pooling read DMA ingress, request side types
 * read request payload, context queue entry for egress
 * and the cube walk position flags
 */
package cdp_rdma_req_pkg;

  // ==============================
  // read request
  // ==============================
  // atoms in a request minus one, 0..7
  typedef logic [2:0] req_size_t;

  typedef struct packed {
    req_size_t size;
    logic [cdp_rdma_cfg_pkg::addr_w_c-1:0] addr;
  } dma_rd_req_t;

  // ==============================
  // context queue entry
  // ==============================
  // egress uses the flags to know where the
  // returning data sits in the cube
  typedef struct packed {
    logic last_c;
    logic last_h;
    logic last_w;
    req_size_t size;
  } cq_entry_t;

  // ==============================
  // walk position
  // ==============================
  typedef struct packed {
    // last width group of the line
    logic last_w;
    // last channel group of the width group
    logic last_c;
    // last line of the cube
    logic last_h;
  } walk_pos_t;

endpackage

// File: logic/cdp_rdma_stall_perf.sv
/*
 * pooling read DMA ingress stall counter
 * counts cycles where the request waits on the DMA port,
 * result lands in two ping-pong perf registers per layer
 */
`timescale 1ns/1ps

module cdp_rdma_stall_perf (
  input  logic                                  nvdla_core_clk,
  input  logic                                  nvdla_core_rstn,
  input  logic                                  dma_en,
  input  logic                                  dma_req_valid,
  input  logic                                  dma_req_ready,
  input  logic                                  layer_done,
  output logic [cdp_rdma_cfg_pkg::perf_w_c-1:0] perf_stall_d0,
  output logic [cdp_rdma_cfg_pkg::perf_w_c-1:0] perf_stall_d1
);

  import cdp_rdma_cfg_pkg::*;

  logic [perf_w_c-1:0] stall_cnt;
  logic                stall;
  logic                layer_flag;

  // request offered but memory not taking it
  assign stall = dma_en & dma_req_valid & ~dma_req_ready;

  // ==============================
  // stall count, per layer
  // ==============================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stall_cnt <= '0;
    end else if (layer_done) begin
      stall_cnt <= '0;
    end else if (stall) begin
      stall_cnt <= stall_cnt + 1'b1;
    end
  end

  // selects d0 or d1, first layer to d0
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      layer_flag <= 1'b0;
    end else if (layer_done) begin
      layer_flag <= ~layer_flag;
    end
  end

  // ping-pong result registers
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      perf_stall_d0 <= '0;
      perf_stall_d1 <= '0;
    end else if (layer_done) begin
      if (layer_flag) begin
        perf_stall_d1 <= stall_cnt;
      end else begin
        perf_stall_d0 <= stall_cnt;
      end
    end
  end

endmodule

// File: tb/cdp_rdma_ig_tb.sv
/*
 * testbench for the pooling read DMA ingress stage
 * runs a table of layers under random back-pressure and checks
 * requests, context entries, joint accept, hold and perf registers
 */
`timescale 1ns/1ps

module cdp_rdma_ig_tb;

  import cdp_rdma_cfg_pkg::*;
  import cdp_rdma_req_pkg::*;

  localparam int num_layers = 5;

  // one table row holds the layer config and the ready drop rate in percent
  typedef struct packed {
    cdp_rdma_cfg_t cfg;
    logic [6:0]    drop_pct;
  } layer_t;

  // one expected walk step
  typedef struct packed {
    logic [addr_w_c-1:0] addr;
    req_size_t           size;
    logic                last_c;
    logic                last_h;
    logic                last_w;
  } step_t;

  logic                nvdla_core_clk;
  logic                nvdla_core_rstn;
  logic                op_en;
  cdp_rdma_cfg_t       cfg;
  logic                eg2ig_done;
  logic                dma_req_valid;
  logic                dma_req_ready;
  dma_rd_req_t         dma_req_pd;
  logic                cq_valid;
  logic                cq_ready;
  cq_entry_t           cq_pd;
  logic [perf_w_c-1:0] perf_stall_d0;
  logic [perf_w_c-1:0] perf_stall_d1;

  layer_t layers [num_layers];
  step_t  exp_q[$];
  int     err_cnt;
  int     check_cnt;
  int     cycle_cnt;
  int     cycle_limit;
  int     layer_idx;
  int     step_idx;
  int     drop;
  int     stall_cnt;
  int     layer_stalls;
  int     perf_exp [2];
  logic   layer_finished;
  logic   holding;

  cdp_rdma_ig UUT (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_en           (op_en),
    .cfg             (cfg),
    .eg2ig_done      (eg2ig_done),
    .dma_req_valid   (dma_req_valid),
    .dma_req_ready   (dma_req_ready),
    .dma_req_pd      (dma_req_pd),
    .cq_valid        (cq_valid),
    .cq_ready        (cq_ready),
    .cq_pd           (cq_pd),
    .perf_stall_d0   (perf_stall_d0),
    .perf_stall_d1   (perf_stall_d1)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #10 nvdla_core_clk = ~nvdla_core_clk;
  end

  // ==============================
  // helpers
  // ==============================
  task automatic compare_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
    check_cnt++;
    assert (exp == act) else begin
      $display("Error %s: expected 0x%0h, actual 0x%0h", what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic add_layer(input int idx, input int ch, input int ht, input int wd,
                           input logic [63:0] base, input logic [31:0] line_s,
                           input logic [31:0] surf_s, input logic en, input int pct);
    layers[idx].cfg      = '{channel: dim_t'(ch), height: dim_t'(ht), width: dim_t'(wd),
                             base_addr: base, line_stride: line_s,
                             surf_stride: surf_s, dma_en: en};
    layers[idx].drop_pct = 7'(pct);
  endtask

  // number of walk steps in a cube
  function automatic int step_count(input cdp_rdma_cfg_t c);
    int n_cg;
    int n_wg;
    n_cg = int'(c.channel) / atom_bytes_c + 1;
    n_wg = (int'(c.width) + w_group_c) / w_group_c;
    return n_cg * n_wg * (int'(c.height) + 1);
  endfunction

  // reference walk of one cube
  task automatic build_steps(input cdp_rdma_cfg_t c);
    int          n_cg;
    int          n_wg;
    int          left;
    logic [63:0] grp_addr;
    step_t       s;
    n_cg = int'(c.channel) / atom_bytes_c + 1;
    n_wg = (int'(c.width) + w_group_c) / w_group_c;
    exp_q.delete();
    for (int h = 0; h <= int'(c.height); h++) begin
      grp_addr = c.base_addr + 64'(h) * c.line_stride;
      for (int wg = 0; wg < n_wg; wg++) begin
        // partial group only at the end of the line
        left   = int'(c.width) + 1 - wg * w_group_c;
        s.size = 3'(((left < w_group_c) ? left : w_group_c) - 1);
        for (int cg = 0; cg < n_cg; cg++) begin
          s.addr   = grp_addr + 64'(cg) * c.surf_stride;
          s.last_c = (cg == n_cg - 1);
          s.last_w = (wg == n_wg - 1);
          s.last_h = (h == int'(c.height));
          exp_q.push_back(s);
        end
        grp_addr = grp_addr + 64'((int'(s.size) + 1) * atom_bytes_c);
      end
    end
  endtask

  task automatic start_layer(input int idx);
    cfg            = layers[idx].cfg;
    drop           = int'(layers[idx].drop_pct);
    layer_idx      = idx;
    step_idx       = 0;
    layer_finished = 1'b0;
    build_steps(layers[idx].cfg);
  endtask

  task automatic drive_ready();
    dma_req_ready = (($urandom % 100) >= drop);
    cq_ready      = (($urandom % 100) >= drop);
  endtask

  // ==============================
  // monitor
  // ==============================
  // sees the values from before the clock edge
  always @(posedge nvdla_core_clk) begin
    logic  dma_acc;
    logic  cq_acc;
    step_t s;
    if (nvdla_core_rstn) begin
      dma_acc = dma_req_valid & dma_req_ready;
      cq_acc  = cq_valid & cq_ready;
      compare_value("joint accept", 64'(cq_acc), 64'(dma_acc));
      if (cfg.dma_en && dma_req_valid && !dma_req_ready) begin
        stall_cnt++;
      end
      // nothing may be offered while egress still drains
      assert (!(holding && (dma_req_valid || cq_valid))) else begin
        $display("a valid rose before eg2ig_done in the hold after layer %0d", layer_idx);
        err_cnt++;
      end
      if (eg2ig_done) begin
        holding = 1'b0;
      end
      if (dma_acc) begin
        assert (exp_q.size() != 0) else begin
          $display("request accepted with no step left in layer %0d", layer_idx);
          err_cnt++;
        end
        if (exp_q.size() != 0) begin
          s = exp_q.pop_front();
          compare_value($sformatf("layer %0d step %0d addr", layer_idx, step_idx),
                        s.addr, dma_req_pd.addr);
          compare_value($sformatf("layer %0d step %0d size", layer_idx, step_idx),
                        64'(s.size), 64'(dma_req_pd.size));
          compare_value($sformatf("layer %0d step %0d cq size", layer_idx, step_idx),
                        64'(s.size), 64'(cq_pd.size));
          compare_value($sformatf("layer %0d step %0d cq flags c/h/w", layer_idx, step_idx),
                        64'({s.last_c, s.last_h, s.last_w}),
                        64'({cq_pd.last_c, cq_pd.last_h, cq_pd.last_w}));
          step_idx++;
          // last step of the cube
          if (exp_q.size() == 0) begin
            layer_stalls   = stall_cnt;
            stall_cnt      = 0;
            layer_finished = 1'b1;
            holding        = 1'b1;
          end
        end
      end
    end
  end

  // run limit of 20 cycles per step plus a bubble allowance per layer
  always @(posedge nvdla_core_clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  // ==============================
  // stimulus
  // ==============================
  initial begin
    int total_steps;
    void'($urandom(32'ha671_1e25));
    nvdla_core_rstn = 1'b0;
    op_en           = 1'b0;
    cfg             = '0;
    eg2ig_done      = 1'b0;
    dma_req_ready   = 1'b0;
    cq_ready        = 1'b0;
    err_cnt         = 0;
    check_cnt       = 0;
    cycle_cnt       = 0;
    stall_cnt       = 0;
    perf_exp[0]     = 0;
    perf_exp[1]     = 0;
    holding         = 1'b0;
    drop            = 0;
    // one width group
    add_layer(0, 31, 0, 5, 64'h0000_0012_3400_0000, 32'h800, 32'h200, 1'b1, 30);
    // three width groups with a partial last one and no stall counting
    add_layer(1, 31, 1, 20, 64'h0000_0000_0000_8000, 32'h1000, 32'h400, 1'b0, 40);
    // three channel groups
    add_layer(2, 95, 0, 15, 64'h0000_0000_0002_0000, 32'h1000, 32'h2000, 1'b1, 25);
    // four lines
    add_layer(3, 63, 3, 9, 64'h0000_0040_0000_0000, 32'h3000, 32'h800, 1'b1, 35);
    // all dimensions at once under heavy back-pressure
    add_layer(4, 127, 2, 26, 64'h0000_0000_ffff_0000, 32'h4_0000, 32'h1_0000, 1'b1, 50);
    total_steps = 0;
    for (int i = 0; i < num_layers; i++) begin
      total_steps += step_count(layers[i].cfg);
    end
    cycle_limit = total_steps * 20 + num_layers * 40 + 30;

    repeat (10) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
    @(negedge nvdla_core_clk);
    compare_value("reset dma_req_valid", 64'd0, 64'(dma_req_valid));
    compare_value("reset cq_valid", 64'd0, 64'(cq_valid));
    compare_value("reset perf_stall_d0", 64'd0, 64'(perf_stall_d0));
    compare_value("reset perf_stall_d1", 64'd0, 64'(perf_stall_d1));

    start_layer(0);
    op_en = 1'b1;
    for (int i = 0; i < num_layers; i++) begin
      while (!layer_finished) begin
        @(negedge nvdla_core_clk);
        drive_ready();
      end
      // op_en stays high while the block sits in the hold
      repeat (4) begin
        @(negedge nvdla_core_clk);
        drive_ready();
      end
      // even layers land in d0 and odd layers in d1
      perf_exp[i % 2] = layer_stalls;
      compare_value($sformatf("layer %0d perf_stall_d0", i), 64'(perf_exp[0]),
                    64'(perf_stall_d0));
      compare_value($sformatf("layer %0d perf_stall_d1", i), 64'(perf_exp[1]),
                    64'(perf_stall_d1));
      @(negedge nvdla_core_clk);
      eg2ig_done = 1'b1;
      if (i + 1 < num_layers) begin
        start_layer(i + 1);
      end else begin
        op_en = 1'b0;
      end
      @(negedge nvdla_core_clk);
      eg2ig_done = 1'b0;
    end
    // no stray requests after the last layer
    repeat (5) @(negedge nvdla_core_clk);

    $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
